/* src/video_timing_pkg.sv */
package video_timing_pkg;

   typedef logic [9:0] coord_t;                  // unsigned raster x or y

   // horizontal geometry in pixel clocks
   localparam int h_active = 640;                // visible pixels
   localparam int h_front  = 16;                 // front porch
   localparam int h_sync   = 96;                 // sync pulse width
   localparam int h_back   = 48;                 // back porch
   localparam int h_total  = h_active + h_front + h_sync + h_back;   // 800 per line

   // vertical geometry in lines
   localparam int v_active = 480;                // visible lines
   localparam int v_front  = 10;                 // front porch
   localparam int v_sync   = 2;                  // sync pulse height
   localparam int v_back   = 33;                 // back porch
   localparam int v_total  = v_active + v_front + v_sync + v_back;   // 525 per frame

   localparam logic sync_active_level = 1'b0;    // hs and vs pulse low

   // counter decode points
   localparam coord_t h_vis_end    = coord_t'(h_active);                      // first blank px
   localparam coord_t h_sync_begin = coord_t'(h_active + h_front);            // 656
   localparam coord_t h_sync_end   = coord_t'(h_active + h_front + h_sync);   // 752
   localparam coord_t h_last       = coord_t'(h_total - 1);                   // wrap point

   localparam coord_t v_vis_end    = coord_t'(v_active);                      // first blank line
   localparam coord_t v_sync_begin = coord_t'(v_active + v_front);            // 490
   localparam coord_t v_sync_end   = coord_t'(v_active + v_front + v_sync);   // 492
   localparam coord_t v_last       = coord_t'(v_total - 1);                   // wrap point

endpackage

/* src/sprite_pkg.sv */
package sprite_pkg;

   localparam int sprite_size = 16;              // square edge in pixels

   // 8 bits per channel with red in the top byte
   typedef struct packed {
      logic [7:0] r;
      logic [7:0] g;
      logic [7:0] b;
   } rgb_t;

   localparam rgb_t black_rgb   = rgb_t'(24'h00_00_00);   // forced during blanking
   localparam rgb_t player1_rgb = rgb_t'(24'hf0_d0_20);   // yellow
   localparam rgb_t player2_rgb = rgb_t'(24'h20_c0_f0);   // cyan

   // background stripes from left to right repeating every 256 px
   localparam rgb_t bg_palette [4] = '{
      rgb_t'(24'h18_20_50),                      // dark blue
      rgb_t'(24'h20_50_20),                      // dark green
      rgb_t'(24'h50_20_20),                      // dark red
      rgb_t'(24'h40_40_40)                       // grey
   };

   localparam int bg_stripe_shift = 6;           // x bit that starts the stripe index

   // layers listed in rising priority
   typedef enum logic [1:0] {
      layer_bg,                                  // striped background
      layer_p2,                                  // player 2 square
      layer_p1                                   // player 1 square always on top
   } layer_t;

endpackage

/* src/vga_timing.sv */
module vga_timing (
   input  logic                     clk,
   input  logic                     arst_n,
   output video_timing_pkg::coord_t spot_x,
   output video_timing_pkg::coord_t spot_y,
   output logic                     active,
   output logic                     hs,
   output logic                     vs,
   output logic                     sof
);
   import video_timing_pkg::*;

   coord_t h_cnt;                                // pixel within line
   coord_t v_cnt;                                // line within frame
   logic   h_wrap;                               // last pixel of a line
   logic   v_wrap;                               // last line of a frame
   logic   h_vis;                                // pixel column visible
   logic   v_vis;                                // line visible
   logic   h_sync_win;                           // inside hsync pulse
   logic   v_sync_win;                           // inside vsync pulse
   logic   origin;                               // counters at 0,0

   assign h_wrap = (h_cnt == h_last);
   assign v_wrap = (v_cnt == v_last);

   // free running raster counters
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         h_cnt <= '0;
         v_cnt <= '0;
      end else begin
         if (h_wrap) begin
            h_cnt <= '0;
            if (v_wrap) begin
               v_cnt <= '0;                      // new frame
            end else begin
               v_cnt <= v_cnt + 1'b1;
            end
         end else begin
            h_cnt <= h_cnt + 1'b1;
         end
      end
   end

   // window decode off the counters
   assign h_vis      = (h_cnt < h_vis_end);
   assign v_vis      = (v_cnt < v_vis_end);
   assign h_sync_win = (h_cnt >= h_sync_begin) && (h_cnt < h_sync_end);
   assign v_sync_win = (v_cnt >= v_sync_begin) && (v_cnt < v_sync_end);
   assign origin     = (h_cnt == '0) && (v_cnt == '0);

   // every output leaves on a register in the same cycle
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         spot_x <= '0;
         spot_y <= '0;
         active <= 1'b0;
         hs     <= ~sync_active_level;           // idle level
         vs     <= ~sync_active_level;
         sof    <= 1'b0;
      end else begin
         spot_x <= h_cnt;
         spot_y <= v_cnt;
         active <= h_vis && v_vis;
         hs     <= h_sync_win ? sync_active_level : ~sync_active_level;
         vs     <= v_sync_win ? sync_active_level : ~sync_active_level;
         sof    <= origin;                       // one clock per frame
      end
   end

   // hsync sits in horizontal blanking and never over visible pixels
   a_hs_outside_active: assert property (
      @(posedge clk) disable iff (!arst_n)
      active |-> (hs != sync_active_level)
   ) else $error("hsync asserted inside active region");

   // frame pulse marks the raster origin and the next coordinate is pixel 1
   a_sof_at_origin: assert property (
      @(posedge clk) disable iff (!arst_n)
      sof |-> (spot_x == '0) && (spot_y == '0) ##1 (spot_x == coord_t'(1)) && !sof
   ) else $error("sof away from raster origin");

endmodule

/* src/sprite_render.sv */
module sprite_render (
   input  logic                     clk,
   input  logic                     arst_n,
   input  video_timing_pkg::coord_t spot_x,
   input  video_timing_pkg::coord_t spot_y,
   input  logic                     sof,
   input  video_timing_pkg::coord_t pos_x,
   input  video_timing_pkg::coord_t pos_y,
   output logic                     hit
);
   import video_timing_pkg::*;
   import sprite_pkg::*;

   coord_t      lat_x;                           // corner held for the frame
   coord_t      lat_y;
   coord_t      cur_x;                           // corner used for this coordinate
   coord_t      cur_y;
   logic [10:0] end_x;                           // one past right edge without wrap
   logic [10:0] end_y;                           // one past bottom edge
   logic        in_x;
   logic        in_y;

   // new position only at frame start and held until the next one
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         lat_x <= '0;
         lat_y <= '0;
      end else if (sof) begin
         lat_x <= pos_x;
         lat_y <= pos_y;
      end
   end

   // at sof the origin pixel already belongs to the new frame
   assign cur_x = sof ? pos_x : lat_x;
   assign cur_y = sof ? pos_y : lat_y;

   // extra bit so a corner near 1023 cannot wrap the far edge
   assign end_x = {1'b0, cur_x} + 11'(sprite_size);
   assign end_y = {1'b0, cur_y} + 11'(sprite_size);

   assign in_x = (spot_x >= cur_x) && ({1'b0, spot_x} < end_x);
   assign in_y = (spot_y >= cur_y) && ({1'b0, spot_y} < end_y);

   // answer comes one clock after the coordinate
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         hit <= 1'b0;
      end else begin
         hit <= in_x && in_y;
      end
   end

endmodule

/* src/pixel_mixer.sv */
module pixel_mixer (
   input  logic                     clk,
   input  logic                     arst_n,
   input  video_timing_pkg::coord_t spot_x,
   input  logic                     active,
   input  logic                     hs,
   input  logic                     vs,
   input  logic                     hit1,
   input  logic                     hit2,
   output sprite_pkg::rgb_t         rgb,
   output logic                     vga_hs,
   output logic                     vga_vs,
   output logic                     vga_blank
);
   import video_timing_pkg::*;
   import sprite_pkg::*;

   logic [1:0] stripe_idx;                       // which 64 px band
   rgb_t       bg_q;                             // stage 1 background colour
   logic       active_q;                         // stage 1 copies of timing
   logic       hs_q;
   logic       vs_q;
   layer_t     layer;                            // winning layer in stage 1

   // x / 64 mod 4
   assign stripe_idx = spot_x[bg_stripe_shift +: 2];

   // stage 1 background lookup
   always_ff @(posedge clk) begin
      bg_q <= bg_palette[stripe_idx];
   end

   // stage 1 timing delayed to match the renderer hit
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         active_q <= 1'b0;
         hs_q     <= ~sync_active_level;
         vs_q     <= ~sync_active_level;
      end else begin
         active_q <= active;
         hs_q     <= hs;
         vs_q     <= vs;
      end
   end

   // hits arrive aligned with stage 1 and player 1 wins an overlap
   always_comb begin
      if (hit1) begin
         layer = layer_p1;
      end else if (hit2) begin
         layer = layer_p2;
      end else begin
         layer = layer_bg;
      end
   end

   // stage 2 colour and syncs two clocks after the coordinate
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         rgb       <= black_rgb;
         vga_hs    <= ~sync_active_level;
         vga_vs    <= ~sync_active_level;
         vga_blank <= 1'b0;                      // blanking out of reset
      end else begin
         vga_hs    <= hs_q;
         vga_vs    <= vs_q;
         vga_blank <= active_q;                  // high = pixel shown
         if (!active_q) begin
            rgb <= black_rgb;                    // porches and sync stay black
         end else begin
            case (layer)
               layer_p1: rgb <= player1_rgb;
               layer_p2: rgb <= player2_rgb;
               default:  rgb <= bg_q;
            endcase
         end
      end
   end

   // no colour leaks into blanking
   a_black_when_blank: assert property (
      @(posedge clk) disable iff (!arst_n)
      !vga_blank |-> (rgb == black_rgb)
   ) else $error("colour present during blanking");

endmodule

/* src/game_display.sv */
module game_display (
   input  logic                     clk,
   input  logic                     arst_n,
   input  video_timing_pkg::coord_t player1_x,
   input  video_timing_pkg::coord_t player1_y,
   input  video_timing_pkg::coord_t player2_x,
   input  video_timing_pkg::coord_t player2_y,
   output logic [7:0]               vga_r,
   output logic [7:0]               vga_g,
   output logic [7:0]               vga_b,
   output logic                     vga_hs,
   output logic                     vga_vs,
   output logic                     vga_blank
);
   import video_timing_pkg::*;
   import sprite_pkg::*;

   coord_t spot_x;                               // raster column
   coord_t spot_y;                               // raster line
   logic   active;                               // visible region
   logic   hs;                                   // raw syncs before the delay
   logic   vs;
   logic   sof;                                  // frame start pulse
   logic   hit1;                                 // player 1 covers pixel
   logic   hit2;                                 // player 2 covers pixel
   rgb_t   rgb;                                  // mixed pixel

   // raster timing
   vga_timing timing (
      .clk    (clk),
      .arst_n (arst_n),
      .spot_x (spot_x),
      .spot_y (spot_y),
      .active (active),
      .hs     (hs),
      .vs     (vs),
      .sof    (sof)
   );

   // player 1 square
   sprite_render p1 (
      .clk    (clk),
      .arst_n (arst_n),
      .spot_x (spot_x),
      .spot_y (spot_y),
      .sof    (sof),
      .pos_x  (player1_x),
      .pos_y  (player1_y),
      .hit    (hit1)
   );

   // player 2 square
   sprite_render p2 (
      .clk    (clk),
      .arst_n (arst_n),
      .spot_x (spot_x),
      .spot_y (spot_y),
      .sof    (sof),
      .pos_x  (player2_x),
      .pos_y  (player2_y),
      .hit    (hit2)
   );

   // background, priority and sync alignment
   pixel_mixer mix (
      .clk       (clk),
      .arst_n    (arst_n),
      .spot_x    (spot_x),
      .active    (active),
      .hs        (hs),
      .vs        (vs),
      .hit1      (hit1),
      .hit2      (hit2),
      .rgb       (rgb),
      .vga_hs    (vga_hs),
      .vga_vs    (vga_vs),
      .vga_blank (vga_blank)
   );

   // channel split for the DAC pins
   assign vga_r = rgb.r;
   assign vga_g = rgb.g;
   assign vga_b = rgb.b;

endmodule

/* dv/tb_game_display.sv */
module tb_game_display;
   timeunit 1ns;
   timeprecision 100ps;
   import video_timing_pkg::*;
   import sprite_pkg::*;

   localparam int n_tests      = 5;
   localparam int max_probes   = 10;
   localparam int frame_clocks = h_total * v_total;   // 420000
   localparam int off_screen   = 1000;                // raster never gets there

   logic       clk;
   logic       arst_n;
   coord_t     player1_x;
   coord_t     player1_y;
   coord_t     player2_x;
   coord_t     player2_y;
   logic [7:0] vga_r;
   logic [7:0] vga_g;
   logic [7:0] vga_b;
   logic       vga_hs;
   logic       vga_vs;
   logic       vga_blank;

   // frame table with name, corners and probe points with expected colour
   string name_tab [n_tests];
   int    pos_tab [n_tests][4];
   int    probe_cnt [n_tests];
   int    probe_x [n_tests][max_probes];
   int    probe_y [n_tests][max_probes];
   rgb_t  probe_exp [n_tests][max_probes];
   int    n_loaded;

   int   cur_entry;                              // -1 until the first entry applies
   int   px;                                     // own raster position in visible px
   int   py;
   int   probes_seen;
   int   test_errs;
   int   errors;
   int   failed_tests;
   int   sync_errs;
   int   sync_checks;
   int   blank_errs;
   int   hs_low;                                 // clocks in current low run
   int   hs_period;                              // clocks since last falling edge
   int   vs_low;
   int   vs_period;
   logic prev_hs;
   logic prev_vs;
   logic prev_blank;
   logic hs_seen;
   logic vs_seen;
   rgb_t act;

   game_display uut (
      .clk       (clk),
      .arst_n    (arst_n),
      .player1_x (player1_x),
      .player1_y (player1_y),
      .player2_x (player2_x),
      .player2_y (player2_y),
      .vga_r     (vga_r),
      .vga_g     (vga_g),
      .vga_b     (vga_b),
      .vga_hs    (vga_hs),
      .vga_vs    (vga_vs),
      .vga_blank (vga_blank)
   );

   always #50 clk = ~clk;                        // 100 ns period

   function automatic bit in_square(int x, int y, int cx, int cy);
      return (x >= cx) && (x < cx + sprite_size) && (y >= cy) && (y < cy + sprite_size);
   endfunction

   // reference pixel with player 1 over player 2 over the stripe
   function automatic rgb_t expected_pixel(int x, int y, int ax, int ay, int bx, int by);
      logic [1:0] idx;
      rgb_t       c;
      idx = 2'((x / 64) % 4);                    // four colours in 64 px bands
      c   = bg_palette[idx];
      if (in_square(x, y, bx, by)) c = player2_rgb;
      if (in_square(x, y, ax, ay)) c = player1_rgb;
      return c;
   endfunction

   task automatic add_entry(string name, int ax, int ay, int bx, int by);
      name_tab[n_loaded]   = name;
      pos_tab[n_loaded]    = '{ax, ay, bx, by};
      probe_cnt[n_loaded]  = 0;
      n_loaded++;
   endtask

   task automatic add_probe(int x, int y);
      int e;
      int k;
      e = n_loaded - 1;
      k = probe_cnt[e];
      probe_x[e][k]   = x;
      probe_y[e][k]   = y;
      probe_exp[e][k] = expected_pixel(x, y, pos_tab[e][0], pos_tab[e][1],
                                       pos_tab[e][2], pos_tab[e][3]);
      probe_cnt[e]++;
   endtask

   task automatic load_table();
      add_entry("stripes_no_players", off_screen, off_screen, off_screen, off_screen);
      for (int k = 0; k < 5; k++) begin
         add_probe(64 * k, 100);                 // first and last px of each band
         add_probe(64 * k + 63, 100);
      end
      add_entry("player1_alone", 100, 50, off_screen, off_screen);
      add_probe(100, 50);
      add_probe(115, 65);
      add_probe(107, 57);
      add_probe(115, 50);
      add_probe(99, 57);                         // just outside each edge
      add_probe(116, 57);
      add_probe(107, 49);
      add_probe(107, 66);
      add_entry("players_overlap", 200, 200, 208, 208);
      add_probe(200, 200);
      add_probe(208, 208);                       // overlap
      add_probe(215, 215);
      add_probe(207, 215);
      add_probe(220, 220);                       // player 2 only
      add_probe(223, 223);
      add_probe(224, 224);
      add_entry("position_change", 300, 300, off_screen, off_screen);
      add_probe(300, 300);
      add_probe(315, 315);
      add_probe(316, 300);
      add_probe(200, 200);                       // old corners now show background
      add_probe(215, 215);
      add_probe(208, 208);
      add_entry("player2_corner", off_screen, off_screen, 624, 464);
      add_probe(624, 464);
      add_probe(639, 479);
      add_probe(623, 464);
   endtask

   task automatic apply_entry(int i);
      player1_x   <= coord_t'(pos_tab[i][0]);
      player1_y   <= coord_t'(pos_tab[i][1]);
      player2_x   <= coord_t'(pos_tab[i][2]);
      player2_y   <= coord_t'(pos_tab[i][3]);
      cur_entry   = i;
      probes_seen = 0;
      test_errs   = 0;
   endtask

   // mid-frame move that the latched corners must ignore until the next sof
   task automatic swap_players(int i);
      player1_x <= coord_t'(pos_tab[i][2]);
      player1_y <= coord_t'(pos_tab[i][3]);
      player2_x <= coord_t'(pos_tab[i][0]);
      player2_y <= coord_t'(pos_tab[i][1]);
   endtask

   task automatic check_count(string name, int expected, int actual);
      sync_checks++;
      assert (expected == actual) else begin
         $display("[FAIL] %s: expected %0d, actual %0d", name, expected, actual);
         sync_errs++;
         errors++;
      end
   endtask

   task automatic check_probes();
      int e;
      e = cur_entry;
      if (e >= 0) begin
         for (int k = 0; k < probe_cnt[e]; k++) begin
            if (probe_x[e][k] == px && probe_y[e][k] == py) begin
               probes_seen++;
               assert (act == probe_exp[e][k]) else begin
                  $display("[FAIL] %s: at (%0d,%0d) expected %06h, actual %06h",
                           name_tab[e], px, py, probe_exp[e][k], act);
                  test_errs++;
                  errors++;
               end
            end
         end
      end
   endtask

   task automatic report_test(int e);
      assert (probes_seen == probe_cnt[e]) else begin
         $display("%s: only %0d of %0d probe points were reached",
                  name_tab[e], probes_seen, probe_cnt[e]);
         test_errs++;
         errors++;
      end
      if (test_errs != 0) failed_tests++;
      $display("test %s: %s, %0d probes, %0d errors", name_tab[e],
               (test_errs == 0) ? "ok" : "FAILED", probes_seen, test_errs);
   endtask

   // outputs move on posedge so look at them on negedge
   always @(negedge clk) begin
      if (arst_n) begin
         act = {vga_r, vga_g, vga_b};
         assert (vga_blank || act == black_rgb) else begin
            $display("[FAIL] blank_black: expected %06h, actual %06h", black_rgb, act);
            blank_errs++;
            errors++;
         end
         if (vga_blank) begin
            check_probes();
            px++;
         end else if (prev_blank) begin
            check_count("active_width", h_active, px);   // end of a visible line
            px = 0;
            py++;
         end
         if (!vga_vs) begin
            px = 0;
            py = 0;
         end
         if (prev_hs && !vga_hs) begin
            if (hs_seen) check_count("hsync_period", h_total, hs_period);
            hs_seen   = 1'b1;
            hs_period = 0;
         end
         if (!prev_hs && vga_hs) begin
            check_count("hsync_width", h_sync, hs_low);
            hs_low = 0;
         end
         if (prev_vs && !vga_vs) begin
            if (vs_seen) check_count("vsync_period", frame_clocks, vs_period);
            vs_seen   = 1'b1;
            vs_period = 0;
         end
         if (!prev_vs && vga_vs) begin
            check_count("vsync_width", v_sync * h_total, vs_low);
            vs_low = 0;
         end
         if (!vga_hs) hs_low++;
         if (!vga_vs) vs_low++;
         hs_period++;
         vs_period++;
         prev_hs    = vga_hs;
         prev_vs    = vga_vs;
         prev_blank = vga_blank;
      end
   end

   // a position set after vsync falls shows up from the next sof
   initial begin
      clk = 1'b0;
      arst_n = 1'b0;
      player1_x = coord_t'(off_screen);
      player1_y = coord_t'(off_screen);
      player2_x = coord_t'(off_screen);
      player2_y = coord_t'(off_screen);
      n_loaded = 0;
      cur_entry = -1;
      px           = 0;
      py           = 0;
      probes_seen  = 0;
      test_errs    = 0;
      errors       = 0;
      failed_tests = 0;
      sync_errs    = 0;
      sync_checks  = 0;
      blank_errs   = 0;
      hs_low       = 0;
      hs_period    = 0;
      vs_low       = 0;
      vs_period    = 0;
      prev_hs      = 1'b1;                       // syncs idle high out of reset
      prev_vs      = 1'b1;
      prev_blank   = 1'b0;
      hs_seen      = 1'b0;
      vs_seen      = 1'b0;
      load_table();
      repeat (16) @(posedge clk);
      arst_n <= 1'b1;
      for (int i = 0; i < n_tests; i++) begin
         @(negedge vga_vs);
         if (i > 0) report_test(i - 1);
         @(posedge clk);
         apply_entry(i);
         @(posedge vga_blank);                   // entry latched at this frame's sof
         @(posedge clk);
         swap_players(i);
      end
      @(negedge vga_vs);
      report_test(n_tests - 1);
      assert (sync_checks > 0) else begin
         $display("no sync or blank edges were seen");
         sync_errs++;
         errors++;
      end
      if (sync_errs != 0) failed_tests++;
      if (blank_errs != 0) failed_tests++;
      $display("test sync_structure: %s, %0d checks, %0d errors",
               (sync_errs == 0) ? "ok" : "FAILED", sync_checks, sync_errs);
      $display("test blank_black: %s, %0d errors", (blank_errs == 0) ? "ok" : "FAILED",
               blank_errs);
      $display("summary: %0d tests, %0d failed, %0d errors", n_tests + 2, failed_tests,
               errors);
      if (errors == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

   // one frame per entry plus the wait for the first vsync and some slack
   initial begin
      repeat ((n_tests + 2) * frame_clocks) @(posedge clk);
      $display("watchdog expired before all frames were checked");
      $display("Finished with errors");
      $finish;
   end

endmodule

/* flist.f */
src/video_timing_pkg.sv
src/sprite_pkg.sv
src/vga_timing.sv
src/sprite_render.sv
src/pixel_mixer.sv
src/game_display.sv
dv/tb_game_display.sv

/* Makefile */
# Verilator build and run for the game display testbench

VERILATOR ?= verilator
TOP       ?= tb_game_display
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
FAIL_MSG  ?= Finished with errors
PASS_MSG  ?= Finished with no errors

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FLIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation stopped without a result, see $(LOG)"; \
		exit 1; \
	fi
	@echo "simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
